// ==== la32_params.svh ====
`ifndef LA32_PARAMS_SVH
`define LA32_PARAMS_SVH

`define LA_XLEN        32
`define LA_REGS_AW     5
`define LA_CSR_AW      14
`define LA_PLV_W       2
`define LA_EXC_STAGES  6
`define LA_EXC_ID_SLOT 2        // Slot owned by the decode stage.
`define LA_CSR_CRMD    14'h0000 // Current-mode CSR, PLV sits in its low bits.

// Three-register and shift-immediate forms, compared against bits 31:15.
`define LA_OP_ADD_W   17'h00020
`define LA_OP_SUB_W   17'h00022
`define LA_OP_SLT     17'h00024
`define LA_OP_SLTU    17'h00025
`define LA_OP_NOR     17'h00028
`define LA_OP_AND     17'h00029
`define LA_OP_OR      17'h0002A
`define LA_OP_XOR     17'h0002B
`define LA_OP_SLL_W   17'h0002E
`define LA_OP_SRL_W   17'h0002F
`define LA_OP_SRA_W   17'h00030
`define LA_OP_BREAK   17'h00054
`define LA_OP_SYSCALL 17'h00056
`define LA_OP_SLLI_W  17'h00081
`define LA_OP_SRLI_W  17'h00089
`define LA_OP_SRAI_W  17'h00091
`define LA_OP_IDLE    17'h00C91

`define LA_OP_SLTI   10'h008 // Bits 31:22.
`define LA_OP_SLTUI  10'h009
`define LA_OP_ADDI_W 10'h00A
`define LA_OP_ANDI   10'h00D
`define LA_OP_ORI    10'h00E
`define LA_OP_XORI   10'h00F
`define LA_OP_LD_B   10'h0A0
`define LA_OP_LD_H   10'h0A1
`define LA_OP_LD_W   10'h0A2
`define LA_OP_ST_B   10'h0A4
`define LA_OP_ST_H   10'h0A5
`define LA_OP_ST_W   10'h0A6
`define LA_OP_LD_BU  10'h0A8
`define LA_OP_LD_HU  10'h0A9

`define LA_OP_LU12I_W   7'h0A // Bits 31:25.
`define LA_OP_PCADDU12I 7'h0E

`define LA_OP_CSR 8'h04 // Bits 31:24, shared by CSRRD, CSRWR and CSRXCHG.

`define LA_OP_JIRL 6'h13 // Bits 31:26.
`define LA_OP_B    6'h14
`define LA_OP_BL   6'h15
`define LA_OP_BEQ  6'h16
`define LA_OP_BNE  6'h17
`define LA_OP_BLT  6'h18
`define LA_OP_BGE  6'h19
`define LA_OP_BLTU 6'h1A
`define LA_OP_BGEU 6'h1B

`define LA_OP_ERTN 22'h1920E // Whole of bits 31:10.

`define LA_CSR_RJ_RD 5'd0
`define LA_CSR_RJ_WR 5'd1

`endif

// ==== id_pkg.sv ====
`default_nettype none

`include "la32_params.svh"

package id_pkg;

  typedef enum logic [5:0] {
    ALU_NOP,
    ALU_ADD_W, ALU_SUB_W, ALU_SLT, ALU_SLTU,
    ALU_AND, ALU_OR, ALU_NOR, ALU_XOR,
    ALU_SLL_W, ALU_SRL_W, ALU_SRA_W,
    ALU_SLTI, ALU_SLTUI, ALU_ADDI_W,
    ALU_ANDI, ALU_ORI, ALU_XORI,
    ALU_SLLI_W, ALU_SRLI_W, ALU_SRAI_W,
    ALU_LU12I_W, ALU_PCADDU12I,
    ALU_LD_B, ALU_LD_H, ALU_LD_W, ALU_LD_BU, ALU_LD_HU,
    ALU_ST_B, ALU_ST_H, ALU_ST_W,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
    ALU_B, ALU_BL, ALU_JIRL,
    ALU_CSRRD, ALU_CSRWR, ALU_CSRXCHG,
    ALU_ERTN, ALU_IDLE, ALU_SYSCALL, ALU_BREAK
  } alu_op_e;

  typedef enum logic [2:0] {
    SEL_NOP,
    SEL_LOGIC,
    SEL_SHIFT,
    SEL_ARITH,
    SEL_LOAD_STORE,
    SEL_BRANCH
  } alu_sel_e;

  typedef enum logic [6:0] {
    EXC_NOP = 7'h00,
    EXC_SYS = 7'h0B,
    EXC_BRK = 7'h0C,
    EXC_INE = 7'h0D,
    EXC_IPE = 7'h0E
  } exc_cause_e;

  typedef struct packed {
    logic [`LA_XLEN-1:0]                  pc;
    logic [`LA_XLEN-1:0]                  inst;
    logic [`LA_EXC_STAGES-1:0]            exc_vec;
    exc_cause_e [`LA_EXC_STAGES-1:0]      exc_cause; // One cause per pipeline slot.
  } fetch_pkt_t;

  typedef struct packed {
    logic                  write_en;
    logic [`LA_CSR_AW-1:0] write_addr;
    logic [`LA_XLEN-1:0]   write_data;
  } csr_fwd_t;

  typedef struct packed {
    alu_op_e                aluop;
    alu_sel_e               alusel;
    logic                   reg_write_en;
    logic [`LA_REGS_AW-1:0] reg_write_addr;
    logic                   reg1_read_en;
    logic [`LA_REGS_AW-1:0] reg1_read_addr;
    logic                   reg2_read_en;
    logic [`LA_REGS_AW-1:0] reg2_read_addr;
    logic [`LA_XLEN-1:0]    imm;
    logic                   csr_read_en;
    logic                   csr_write_en;
    logic [`LA_CSR_AW-1:0]  csr_addr;
  } uop_t;

  typedef struct packed {
    logic       hit;
    logic       exc;
    exc_cause_e cause;
    uop_t       uop;
  } dec_res_t;

  typedef struct packed {
    logic [`LA_XLEN-1:0]             pc;
    logic [`LA_XLEN-1:0]             inst;
    uop_t                            uop;
    logic [`LA_EXC_STAGES-1:0]       exc_vec;
    exc_cause_e [`LA_EXC_STAGES-1:0] exc_cause;
  } id_dispatch_t;

endpackage

`default_nettype wire

// ==== dec_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la32_params.svh"

module dec_alu (
  input  logic [`LA_XLEN-1:0] inst,
  output id_pkg::dec_res_t    res
);
  import id_pkg::*;

  alu_op_e                op;
  logic                   hit;
  logic [`LA_REGS_AW-1:0] rd;
  logic [`LA_REGS_AW-1:0] rj;
  logic [`LA_REGS_AW-1:0] rk;
  logic [11:0]            i12;
  logic [4:0]             ui5;
  logic [19:0]            i20;

  assign rd  = inst[4:0];
  assign rj  = inst[9:5];
  assign rk  = inst[14:10];
  assign i12 = inst[21:10];
  assign ui5 = inst[14:10];
  assign i20 = inst[24:5];
  assign hit = (op != ALU_NOP);

  always_comb begin
    op = ALU_NOP;
    case (inst[31:15])
      `LA_OP_ADD_W:  op = ALU_ADD_W;
      `LA_OP_SUB_W:  op = ALU_SUB_W;
      `LA_OP_SLT:    op = ALU_SLT;
      `LA_OP_SLTU:   op = ALU_SLTU;
      `LA_OP_NOR:    op = ALU_NOR;
      `LA_OP_AND:    op = ALU_AND;
      `LA_OP_OR:     op = ALU_OR;
      `LA_OP_XOR:    op = ALU_XOR;
      `LA_OP_SLL_W:  op = ALU_SLL_W;
      `LA_OP_SRL_W:  op = ALU_SRL_W;
      `LA_OP_SRA_W:  op = ALU_SRA_W;
      `LA_OP_SLLI_W: op = ALU_SLLI_W;
      `LA_OP_SRLI_W: op = ALU_SRLI_W;
      `LA_OP_SRAI_W: op = ALU_SRAI_W;
      default: ;
    endcase
    case (inst[31:22])
      `LA_OP_SLTI:   op = ALU_SLTI;
      `LA_OP_SLTUI:  op = ALU_SLTUI;
      `LA_OP_ADDI_W: op = ALU_ADDI_W;
      `LA_OP_ANDI:   op = ALU_ANDI;
      `LA_OP_ORI:    op = ALU_ORI;
      `LA_OP_XORI:   op = ALU_XORI;
      default: ;
    endcase
    case (inst[31:25])
      `LA_OP_LU12I_W:   op = ALU_LU12I_W;
      `LA_OP_PCADDU12I: op = ALU_PCADDU12I;
      default: ;
    endcase
  end

  always_comb begin
    res                    = '0;
    res.hit                = hit;
    res.uop.aluop          = op;
    res.uop.reg_write_en   = hit;          // Every form here writes rd.
    res.uop.reg_write_addr = rd;
    res.uop.reg1_read_en   = hit;
    res.uop.reg1_read_addr = rj;
    res.uop.reg2_read_addr = rk;
    case (op)
      ALU_ADD_W, ALU_SUB_W, ALU_SLT, ALU_SLTU: begin
        res.uop.alusel       = SEL_ARITH;
        res.uop.reg2_read_en = 1'b1;
      end
      ALU_AND, ALU_OR, ALU_NOR, ALU_XOR: begin
        res.uop.alusel       = SEL_LOGIC;
        res.uop.reg2_read_en = 1'b1;
      end
      ALU_SLL_W, ALU_SRL_W, ALU_SRA_W: begin
        res.uop.alusel       = SEL_SHIFT;
        res.uop.reg2_read_en = 1'b1;
      end
      ALU_SLTI, ALU_SLTUI, ALU_ADDI_W: begin
        res.uop.alusel = SEL_ARITH;
        res.uop.imm    = {{(`LA_XLEN-12){i12[11]}}, i12};
      end
      ALU_ANDI, ALU_ORI, ALU_XORI: begin
        res.uop.alusel = SEL_LOGIC;
        res.uop.imm    = {{(`LA_XLEN-12){1'b0}}, i12};
      end
      ALU_SLLI_W, ALU_SRLI_W, ALU_SRAI_W: begin
        res.uop.alusel = SEL_SHIFT;
        res.uop.imm    = {{(`LA_XLEN-5){1'b0}}, ui5};
      end
      ALU_LU12I_W: begin
        res.uop.alusel         = SEL_LOGIC;
        res.uop.reg1_read_addr = '0;     // Computed as r0 plus the upper immediate.
        res.uop.imm            = {i20, 12'b0};
      end
      ALU_PCADDU12I: begin
        res.uop.alusel = SEL_ARITH;
        res.uop.imm    = {i20, 12'b0};
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== dec_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la32_params.svh"

module dec_mem (
  input  logic [`LA_XLEN-1:0] inst,
  output id_pkg::dec_res_t    res
);
  import id_pkg::*;

  alu_op_e                op;
  logic                   hit;
  logic                   is_store;
  logic [`LA_REGS_AW-1:0] rd;
  logic [11:0]            si12;

  assign rd       = inst[4:0];
  assign si12     = inst[21:10];
  assign hit      = (op != ALU_NOP);
  assign is_store = (op == ALU_ST_B) || (op == ALU_ST_H) || (op == ALU_ST_W);

  always_comb begin
    op = ALU_NOP;
    case (inst[31:22])
      `LA_OP_LD_B:  op = ALU_LD_B;
      `LA_OP_LD_H:  op = ALU_LD_H;
      `LA_OP_LD_W:  op = ALU_LD_W;
      `LA_OP_LD_BU: op = ALU_LD_BU;
      `LA_OP_LD_HU: op = ALU_LD_HU;
      `LA_OP_ST_B:  op = ALU_ST_B;
      `LA_OP_ST_H:  op = ALU_ST_H;
      `LA_OP_ST_W:  op = ALU_ST_W;
      default: ;
    endcase
  end

  always_comb begin
    res                    = '0;
    res.hit                = hit;
    res.uop.aluop          = op;
    res.uop.alusel         = hit ? SEL_LOAD_STORE : SEL_NOP;
    res.uop.reg1_read_en   = hit;          // Base address register.
    res.uop.reg1_read_addr = inst[9:5];
    if (is_store) begin
      res.uop.reg2_read_en   = 1'b1;       // Store data comes from rd.
      res.uop.reg2_read_addr = rd;
    end else if (hit) begin
      res.uop.reg_write_en   = 1'b1;
      res.uop.reg_write_addr = rd;
      res.uop.imm            = {{(`LA_XLEN-12){si12[11]}}, si12};
    end
  end

endmodule

`default_nettype wire

// ==== dec_branch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la32_params.svh"

module dec_branch (
  input  logic [`LA_XLEN-1:0] inst,
  output id_pkg::dec_res_t    res
);
  import id_pkg::*;

  localparam logic [`LA_REGS_AW-1:0] REG_RA = 'd1; // Link register for BL.

  alu_op_e                op;
  logic                   hit;
  logic [`LA_REGS_AW-1:0] rd;
  logic [`LA_REGS_AW-1:0] rj;

  assign rd  = inst[4:0];
  assign rj  = inst[9:5];
  assign hit = (op != ALU_NOP);

  always_comb begin
    op = ALU_NOP;
    case (inst[31:26])
      `LA_OP_BEQ:  op = ALU_BEQ;
      `LA_OP_BNE:  op = ALU_BNE;
      `LA_OP_BLT:  op = ALU_BLT;
      `LA_OP_BGE:  op = ALU_BGE;
      `LA_OP_BLTU: op = ALU_BLTU;
      `LA_OP_BGEU: op = ALU_BGEU;
      `LA_OP_B:    op = ALU_B;
      `LA_OP_BL:   op = ALU_BL;
      `LA_OP_JIRL: op = ALU_JIRL;
      default: ;
    endcase
  end

  // Offsets are left in the instruction word for the execute stage.
  always_comb begin
    res                = '0;
    res.hit            = hit;
    res.uop.aluop      = op;
    res.uop.alusel     = hit ? SEL_BRANCH : SEL_NOP;
    case (op)
      ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU: begin
        res.uop.reg1_read_en   = 1'b1;
        res.uop.reg1_read_addr = rj;
        res.uop.reg2_read_en   = 1'b1;
        res.uop.reg2_read_addr = rd;
      end
      ALU_BL: begin
        res.uop.reg_write_en   = 1'b1;
        res.uop.reg_write_addr = REG_RA;
      end
      ALU_JIRL: begin
        res.uop.reg1_read_en   = 1'b1;
        res.uop.reg1_read_addr = rj;
        res.uop.reg_write_en   = 1'b1;
        res.uop.reg_write_addr = rd;
      end
      default: ;                           // B touches no register.
    endcase
  end

endmodule

`default_nettype wire

// ==== dec_priv.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la32_params.svh"

module dec_priv (
  input  logic [`LA_XLEN-1:0]  inst,
  input  logic [`LA_PLV_W-1:0] plv,
  input  id_pkg::csr_fwd_t     csr_fwd,
  output id_pkg::dec_res_t     res
);
  import id_pkg::*;

  logic [`LA_PLV_W-1:0]   plv_eff;
  logic                   ipe;
  logic [`LA_REGS_AW-1:0] rd;
  logic [`LA_REGS_AW-1:0] rj;

  assign rd = inst[4:0];
  assign rj = inst[9:5];

  // A CRMD write leaving write-back this cycle overrides the stale PLV.
  assign plv_eff = (csr_fwd.write_en && (csr_fwd.write_addr == `LA_CSR_CRMD)) ?
                   csr_fwd.write_data[`LA_PLV_W-1:0] : plv;
  assign ipe     = (plv_eff != '0);

  always_comb begin
    res = '0;
    if (inst[31:24] == `LA_OP_CSR) begin
      res.hit                = 1'b1;
      res.uop.csr_read_en    = 1'b1;
      res.uop.csr_addr       = inst[23:10];
      res.uop.reg_write_en   = 1'b1;       // Old CSR value always returns to rd.
      res.uop.reg_write_addr = rd;
      case (rj)
        `LA_CSR_RJ_RD: res.uop.aluop = ALU_CSRRD;
        `LA_CSR_RJ_WR: begin
          res.uop.aluop          = ALU_CSRWR;
          res.uop.reg1_read_en   = 1'b1;
          res.uop.reg1_read_addr = rd;
          res.uop.csr_write_en   = 1'b1;
        end
        default: begin
          res.uop.aluop          = ALU_CSRXCHG;
          res.uop.reg1_read_en   = 1'b1;
          res.uop.reg1_read_addr = rd;
          res.uop.reg2_read_en   = 1'b1;  // rj holds the write mask.
          res.uop.reg2_read_addr = rj;
          res.uop.csr_write_en   = 1'b1;
        end
      endcase
    end else if (inst[31:10] == `LA_OP_ERTN) begin
      res.hit       = 1'b1;
      res.uop.aluop = ALU_ERTN;
    end else if (inst[31:15] == `LA_OP_IDLE) begin
      res.hit       = 1'b1;
      res.uop.aluop = ALU_IDLE;
    end else if (inst[31:15] == `LA_OP_SYSCALL) begin
      res.hit       = 1'b1;
      res.uop.aluop = ALU_SYSCALL;
    end else if (inst[31:15] == `LA_OP_BREAK) begin
      res.hit       = 1'b1;
      res.uop.aluop = ALU_BREAK;
    end
    if (res.uop.aluop == ALU_SYSCALL) begin
      res.exc   = 1'b1;
      res.cause = EXC_SYS;
    end else if (res.uop.aluop == ALU_BREAK) begin
      res.exc   = 1'b1;
      res.cause = EXC_BRK;
    end else if (res.hit && ipe) begin
      res.exc   = 1'b1;
      res.cause = EXC_IPE;
    end
  end

endmodule

`default_nettype wire

// ==== id_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la32_params.svh"

module id_dispatch (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  id_pkg::fetch_pkt_t   fetch_pkt,
  input  id_pkg::dec_res_t     alu_res,
  input  id_pkg::dec_res_t     mem_res,
  input  id_pkg::dec_res_t     br_res,
  input  id_pkg::dec_res_t     priv_res,
  output logic                 out_valid,
  output id_pkg::id_dispatch_t dispatch
);
  import id_pkg::*;

  dec_res_t                        sel_res;
  logic                            any_hit;
  logic [`LA_EXC_STAGES-1:0]       exc_vec_nxt;
  exc_cause_e [`LA_EXC_STAGES-1:0] exc_cause_nxt;

  assign any_hit = alu_res.hit | mem_res.hit | br_res.hit | priv_res.hit;

  always_comb begin
    sel_res = '0;                          // Empty uop when nothing matches.
    if (alu_res.hit) sel_res = alu_res;
    else if (mem_res.hit) sel_res = mem_res;
    else if (br_res.hit) sel_res = br_res;
    else if (priv_res.hit) sel_res = priv_res;
  end

  always_comb begin
    exc_vec_nxt   = fetch_pkt.exc_vec;
    exc_cause_nxt = fetch_pkt.exc_cause;
    if (any_hit) begin
      exc_vec_nxt[`LA_EXC_ID_SLOT]   = sel_res.exc;
      exc_cause_nxt[`LA_EXC_ID_SLOT] = sel_res.cause;
    end else if (fetch_pkt.inst != '0) begin
      exc_vec_nxt[`LA_EXC_ID_SLOT]   = 1'b1;
      exc_cause_nxt[`LA_EXC_ID_SLOT] = EXC_INE;
    end else begin
      exc_vec_nxt[`LA_EXC_ID_SLOT]   = 1'b0; // All-zero word is a bubble.
      exc_cause_nxt[`LA_EXC_ID_SLOT] = EXC_NOP;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      dispatch.pc        <= fetch_pkt.pc;
      dispatch.inst      <= fetch_pkt.inst;
      dispatch.uop       <= sel_res.uop;
      dispatch.exc_vec   <= exc_vec_nxt;
      dispatch.exc_cause <= exc_cause_nxt;
    end
  end

  a_one_decoder: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> $onehot0({alu_res.hit, mem_res.hit, br_res.hit, priv_res.hit}))
    else $error("More than one decoder matched the instruction.");

  a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
    else $error("out_valid high in the first cycle after reset.");

endmodule

`default_nettype wire

// ==== id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la32_params.svh"

module id_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  id_pkg::fetch_pkt_t   fetch_pkt,
  input  logic [`LA_PLV_W-1:0] plv,
  input  id_pkg::csr_fwd_t     csr_fwd,
  output logic                 out_valid,
  output id_pkg::id_dispatch_t dispatch
);
  import id_pkg::*;

  dec_res_t alu_res;
  dec_res_t mem_res;
  dec_res_t br_res;
  dec_res_t priv_res;

  dec_alu u_dec_alu (
    .inst (fetch_pkt.inst),
    .res  (alu_res)
  );

  dec_mem u_dec_mem (
    .inst (fetch_pkt.inst),
    .res  (mem_res)
  );

  dec_branch u_dec_branch (
    .inst (fetch_pkt.inst),
    .res  (br_res)
  );

  dec_priv u_dec_priv (
    .inst    (fetch_pkt.inst),
    .plv     (plv),
    .csr_fwd (csr_fwd),
    .res     (priv_res)
  );

  id_dispatch u_id_dispatch (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .fetch_pkt (fetch_pkt),
    .alu_res   (alu_res),
    .mem_res   (mem_res),
    .br_res    (br_res),
    .priv_res  (priv_res),
    .out_valid (out_valid),
    .dispatch  (dispatch)
  );

endmodule

`default_nettype wire

// ==== tb_id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la32_params.svh"

module tb_id_stage;
  import id_pkg::*;

  localparam logic [`LA_XLEN-1:0] PC_TAG = 32'h1C00_0000;

  typedef struct {
    string                  name;
    logic [`LA_XLEN-1:0]    inst;
    logic [`LA_PLV_W-1:0]   plv;
    logic                   fwd_en;
    logic [`LA_CSR_AW-1:0]  fwd_addr;
    logic [`LA_XLEN-1:0]    fwd_data;
    logic [`LA_EXC_STAGES-1:0] exc_in;
    alu_op_e                op;
    alu_sel_e               sel;
    logic                   we;
    logic [`LA_REGS_AW-1:0] wa;
    logic                   r1e;
    logic [`LA_REGS_AW-1:0] r1a;
    logic                   r2e;
    logic [`LA_REGS_AW-1:0] r2a;
    logic [`LA_XLEN-1:0]    imm;
    logic                   cre;
    logic                   cwe;
    logic [`LA_CSR_AW-1:0]  caddr;
    logic                   exc;
    exc_cause_e             cause;
  } row_t;

  logic                 clk;
  logic                 rst_n;
  logic                 in_valid;
  fetch_pkt_t           fetch_pkt;
  logic [`LA_PLV_W-1:0] plv;
  csr_fwd_t             csr_fwd;
  logic                 out_valid;
  id_dispatch_t         dispatch;

  row_t                      rows[$];
  logic [`LA_REGS_AW-1:0]    rd;
  logic [`LA_REGS_AW-1:0]    rj;
  logic [`LA_REGS_AW-1:0]    rk;
  logic [`LA_REGS_AW-1:0]    xj;
  logic [11:0]               i12;
  logic [19:0]               i20;
  logic [`LA_CSR_AW-1:0]     csr;
  logic [`LA_EXC_STAGES-1:0] ex;
  logic                      prev_in_valid;
  int                        row_errs;
  int                        rows_ok;
  int                        rows_bad;
  int                        timing_errs;

  id_stage u_id_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .fetch_pkt (fetch_pkt),
    .plv       (plv),
    .csr_fwd   (csr_fwd),
    .out_valid (out_valid),
    .dispatch  (dispatch)
  );

  always #50 clk = ~clk;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_in_valid <= 1'b0;
    end else begin
      prev_in_valid <= in_valid;
    end
  end

  // A packet appears exactly one cycle after each strobe and never otherwise.
  always @(negedge clk) begin
    if (rst_n) begin
      assert (out_valid === prev_in_valid) else begin
        $display("Error: out_valid got %h expected %h", out_valid, prev_in_valid);
        timing_errs++;
      end
    end
  end

  task automatic draw();
    logic [31:0] a;
    logic [31:0] b;
    a   = $urandom;
    b   = $urandom;
    rd  = a[4:0];
    rj  = a[9:5];
    rk  = a[14:10];
    i12 = {1'b1, a[25:15]};           // Negative, so sign and zero extension differ.
    ex  = a[31:26];
    i20 = b[19:0];
    csr = b[31:18];
    xj  = (rj < 5'd2) ? rj + 5'd2 : rj; // CSRXCHG needs rj above 1.
  endtask

  function automatic row_t mk(input string name, input logic [31:0] inst, input alu_op_e op,
                              input alu_sel_e sel, input logic we, input logic [4:0] wa,
                              input logic r1e, input logic [4:0] r1a, input logic r2e,
                              input logic [4:0] r2a, input logic [31:0] imm);
    row_t r;
    r.name     = name;
    r.inst     = inst;
    r.plv      = '0;
    r.fwd_en   = 1'b0;
    r.fwd_addr = '0;
    r.fwd_data = '0;
    r.exc_in   = ex;
    r.op       = op;
    r.sel      = sel;
    r.we       = we;
    r.wa       = wa;
    r.r1e      = r1e;
    r.r1a      = r1a;
    r.r2e      = r2e;
    r.r2a      = r2a;
    r.imm      = imm;
    r.cre      = 1'b0;
    r.cwe      = 1'b0;
    r.caddr    = '0;
    r.exc      = 1'b0;
    r.cause    = EXC_NOP;
    return r;
  endfunction

  function automatic row_t priv(input row_t base, input logic [1:0] lvl, input logic fwd,
                                input logic [13:0] faddr, input logic [1:0] fplv,
                                input logic cre, input logic cwe, input exc_cause_e cause);
    row_t r;
    r          = base;
    r.plv      = lvl;
    r.fwd_en   = fwd;
    r.fwd_addr = faddr;
    r.fwd_data = {30'h3FFF_FFFC, fplv}; // Only the low bits carry the level.
    r.cre      = cre;
    r.cwe      = cwe;
    r.caddr    = csr;
    r.exc      = (cause != EXC_NOP);
    r.cause    = cause;
    return r;
  endfunction

  task automatic build_table();
    row_t r;
    draw();
    rows.push_back(mk("ADD.W", {`LA_OP_ADD_W, rk, rj, rd}, ALU_ADD_W, SEL_ARITH,
                      1'b1, rd, 1'b1, rj, 1'b1, rk, 32'h0));
    draw();
    rows.push_back(mk("SLTU", {`LA_OP_SLTU, rk, rj, rd}, ALU_SLTU, SEL_ARITH,
                      1'b1, rd, 1'b1, rj, 1'b1, rk, 32'h0));
    draw();
    rows.push_back(mk("NOR", {`LA_OP_NOR, rk, rj, rd}, ALU_NOR, SEL_LOGIC,
                      1'b1, rd, 1'b1, rj, 1'b1, rk, 32'h0));
    draw();
    rows.push_back(mk("SRA.W", {`LA_OP_SRA_W, rk, rj, rd}, ALU_SRA_W, SEL_SHIFT,
                      1'b1, rd, 1'b1, rj, 1'b1, rk, 32'h0));
    draw();
    rows.push_back(mk("ADDI.W", {`LA_OP_ADDI_W, i12, rj, rd}, ALU_ADDI_W, SEL_ARITH,
                      1'b1, rd, 1'b1, rj, 1'b0, 5'd0, {{20{i12[11]}}, i12}));
    draw();
    rows.push_back(mk("SLTI", {`LA_OP_SLTI, i12, rj, rd}, ALU_SLTI, SEL_ARITH,
                      1'b1, rd, 1'b1, rj, 1'b0, 5'd0, {{20{i12[11]}}, i12}));
    draw();
    rows.push_back(mk("ANDI", {`LA_OP_ANDI, i12, rj, rd}, ALU_ANDI, SEL_LOGIC,
                      1'b1, rd, 1'b1, rj, 1'b0, 5'd0, {20'h0, i12}));
    draw();
    rows.push_back(mk("SRLI.W", {`LA_OP_SRLI_W, rk, rj, rd}, ALU_SRLI_W, SEL_SHIFT,
                      1'b1, rd, 1'b1, rj, 1'b0, 5'd0, {27'h0, rk}));
    draw();
    rows.push_back(mk("LU12I.W", {`LA_OP_LU12I_W, i20, rd}, ALU_LU12I_W, SEL_LOGIC,
                      1'b1, rd, 1'b1, 5'd0, 1'b0, 5'd0, {i20, 12'h0}));
    draw();
    rows.push_back(mk("PCADDU12I", {`LA_OP_PCADDU12I, i20, rd}, ALU_PCADDU12I, SEL_ARITH,
                      1'b1, rd, 1'b1, i20[4:0], 1'b0, 5'd0, {i20, 12'h0}));
    draw();
    rows.push_back(mk("LD.B", {`LA_OP_LD_B, i12, rj, rd}, ALU_LD_B, SEL_LOAD_STORE,
                      1'b1, rd, 1'b1, rj, 1'b0, 5'd0, {{20{i12[11]}}, i12}));
    draw();
    rows.push_back(mk("LD.HU", {`LA_OP_LD_HU, 1'b0, i12[10:0], rj, rd}, ALU_LD_HU,
                      SEL_LOAD_STORE, 1'b1, rd, 1'b1, rj, 1'b0, 5'd0, {21'h0, i12[10:0]}));
    draw();
    rows.push_back(mk("ST.W", {`LA_OP_ST_W, i12, rj, rd}, ALU_ST_W, SEL_LOAD_STORE,
                      1'b0, 5'd0, 1'b1, rj, 1'b1, rd, 32'h0));
    draw();
    rows.push_back(mk("BEQ", {`LA_OP_BEQ, i20[15:0], rj, rd}, ALU_BEQ, SEL_BRANCH,
                      1'b0, 5'd0, 1'b1, rj, 1'b1, rd, 32'h0));
    draw();
    rows.push_back(mk("BLTU", {`LA_OP_BLTU, i20[15:0], rj, rd}, ALU_BLTU, SEL_BRANCH,
                      1'b0, 5'd0, 1'b1, rj, 1'b1, rd, 32'h0));
    draw();
    rows.push_back(mk("BGEU", {`LA_OP_BGEU, i20[15:0], rj, rd}, ALU_BGEU, SEL_BRANCH,
                      1'b0, 5'd0, 1'b1, rj, 1'b1, rd, 32'h0));
    draw();
    rows.push_back(mk("B", {`LA_OP_B, i20, i12[5:0]}, ALU_B, SEL_BRANCH,
                      1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 5'd0, 32'h0));
    draw();
    rows.push_back(mk("BL", {`LA_OP_BL, i20, i12[5:0]}, ALU_BL, SEL_BRANCH,
                      1'b1, 5'd1, 1'b0, 5'd0, 1'b0, 5'd0, 32'h0));
    draw();
    rows.push_back(mk("JIRL", {`LA_OP_JIRL, i20[15:0], rj, rd}, ALU_JIRL, SEL_BRANCH,
                      1'b1, rd, 1'b1, rj, 1'b0, 5'd0, 32'h0));
    draw();
    r = mk("CSRRD plv0", {`LA_OP_CSR, csr, `LA_CSR_RJ_RD, rd}, ALU_CSRRD, SEL_NOP,
           1'b1, rd, 1'b0, 5'd0, 1'b0, 5'd0, 32'h0);
    rows.push_back(priv(r, 2'd0, 1'b0, 14'h0, 2'd0, 1'b1, 1'b0, EXC_NOP));
    draw();
    r = mk("CSRWR plv0", {`LA_OP_CSR, csr, `LA_CSR_RJ_WR, rd}, ALU_CSRWR, SEL_NOP,
           1'b1, rd, 1'b1, rd, 1'b0, 5'd0, 32'h0);
    rows.push_back(priv(r, 2'd0, 1'b0, 14'h0, 2'd0, 1'b1, 1'b1, EXC_NOP));
    draw();
    r = mk("CSRXCHG plv0", {`LA_OP_CSR, csr, xj, rd}, ALU_CSRXCHG, SEL_NOP,
           1'b1, rd, 1'b1, rd, 1'b1, xj, 32'h0);
    rows.push_back(priv(r, 2'd0, 1'b0, 14'h0, 2'd0, 1'b1, 1'b1, EXC_NOP));
    draw();
    r = mk("CSRRD plv3", {`LA_OP_CSR, csr, `LA_CSR_RJ_RD, rd}, ALU_CSRRD, SEL_NOP,
           1'b1, rd, 1'b0, 5'd0, 1'b0, 5'd0, 32'h0);
    rows.push_back(priv(r, 2'd3, 1'b0, 14'h0, 2'd0, 1'b1, 1'b0, EXC_IPE));
    draw();
    r = mk("CSRWR plv3 fwd0", {`LA_OP_CSR, csr, `LA_CSR_RJ_WR, rd}, ALU_CSRWR, SEL_NOP,
           1'b1, rd, 1'b1, rd, 1'b0, 5'd0, 32'h0);
    rows.push_back(priv(r, 2'd3, 1'b1, `LA_CSR_CRMD, 2'd0, 1'b1, 1'b1, EXC_NOP));
    draw();
    r = mk("CSRXCHG plv0 fwd3", {`LA_OP_CSR, csr, xj, rd}, ALU_CSRXCHG, SEL_NOP,
           1'b1, rd, 1'b1, rd, 1'b1, xj, 32'h0);
    rows.push_back(priv(r, 2'd0, 1'b1, `LA_CSR_CRMD, 2'd3, 1'b1, 1'b1, EXC_IPE));
    draw();
    r = mk("CSRRD plv3 fwd other", {`LA_OP_CSR, csr, `LA_CSR_RJ_RD, rd}, ALU_CSRRD, SEL_NOP,
           1'b1, rd, 1'b0, 5'd0, 1'b0, 5'd0, 32'h0);
    rows.push_back(priv(r, 2'd3, 1'b1, 14'h0001, 2'd0, 1'b1, 1'b0, EXC_IPE));
    draw();
    r = mk("ERTN plv3", {`LA_OP_ERTN, 10'h0}, ALU_ERTN, SEL_NOP,
           1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 5'd0, 32'h0);
    rows.push_back(priv(r, 2'd3, 1'b0, 14'h0, 2'd0, 1'b0, 1'b0, EXC_IPE));
    draw();
    r = mk("IDLE plv0", {`LA_OP_IDLE, i20[14:0]}, ALU_IDLE, SEL_NOP,
           1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 5'd0, 32'h0);
    rows.push_back(priv(r, 2'd0, 1'b0, 14'h0, 2'd0, 1'b0, 1'b0, EXC_NOP));
    draw();
    r = mk("SYSCALL", {`LA_OP_SYSCALL, i20[14:0]}, ALU_SYSCALL, SEL_NOP,
           1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 5'd0, 32'h0);
    rows.push_back(priv(r, 2'd0, 1'b0, 14'h0, 2'd0, 1'b0, 1'b0, EXC_SYS));
    draw();
    r = mk("BREAK plv3", {`LA_OP_BREAK, i20[14:0]}, ALU_BREAK, SEL_NOP,
           1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 5'd0, 32'h0);
    rows.push_back(priv(r, 2'd3, 1'b0, 14'h0, 2'd0, 1'b0, 1'b0, EXC_BRK));
    draw();
    r = mk("unused word", 32'hFFFF_FFFF, ALU_NOP, SEL_NOP,
           1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 5'd0, 32'h0);
    rows.push_back(priv(r, 2'd0, 1'b0, 14'h0, 2'd0, 1'b0, 1'b0, EXC_INE));
    r = mk("zero word", 32'h0, ALU_NOP, SEL_NOP,
           1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 5'd0, 32'h0);
    r.exc_in = '1;                      // Decode slot must come out clear.
    rows.push_back(r);
  endtask

  task automatic drive_row(input row_t r);
    fetch_pkt.pc       = r.inst ^ PC_TAG;
    fetch_pkt.inst     = r.inst;
    fetch_pkt.exc_vec  = r.exc_in;
    for (int i = 0; i < `LA_EXC_STAGES; i++) begin
      fetch_pkt.exc_cause[i] = r.exc_in[i] ? EXC_BRK : EXC_NOP;
    end
    plv                = r.plv;
    csr_fwd.write_en   = r.fwd_en;
    csr_fwd.write_addr = r.fwd_addr;
    csr_fwd.write_data = r.fwd_data;
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: %s got %h expected %h", name, got, exp);
      row_errs++;
    end
  endtask

  task automatic check_row(input row_t r, input string tag);
    logic [`LA_EXC_STAGES-1:0] vec;
    exc_cause_e                cause_exp;
    vec                  = r.exc_in;
    vec[`LA_EXC_ID_SLOT] = r.exc;
    row_errs             = 0;
    check_field("pc", dispatch.pc, r.inst ^ PC_TAG);
    check_field("inst", dispatch.inst, r.inst);
    check_field("aluop", 32'(dispatch.uop.aluop), 32'(r.op));
    check_field("alusel", 32'(dispatch.uop.alusel), 32'(r.sel));
    check_field("reg_write_en", 32'(dispatch.uop.reg_write_en), 32'(r.we));
    if (r.we) check_field("reg_write_addr", 32'(dispatch.uop.reg_write_addr), 32'(r.wa));
    check_field("reg1_read_en", 32'(dispatch.uop.reg1_read_en), 32'(r.r1e));
    if (r.r1e) check_field("reg1_read_addr", 32'(dispatch.uop.reg1_read_addr), 32'(r.r1a));
    check_field("reg2_read_en", 32'(dispatch.uop.reg2_read_en), 32'(r.r2e));
    if (r.r2e) check_field("reg2_read_addr", 32'(dispatch.uop.reg2_read_addr), 32'(r.r2a));
    check_field("imm", dispatch.uop.imm, r.imm);
    check_field("csr_read_en", 32'(dispatch.uop.csr_read_en), 32'(r.cre));
    check_field("csr_write_en", 32'(dispatch.uop.csr_write_en), 32'(r.cwe));
    if (r.cre) check_field("csr_addr", 32'(dispatch.uop.csr_addr), 32'(r.caddr));
    check_field("exc_vec", 32'(dispatch.exc_vec), 32'(vec));
    for (int i = 0; i < `LA_EXC_STAGES; i++) begin
      cause_exp = r.exc_in[i] ? EXC_BRK : EXC_NOP; // Other slots keep the fetch cause.
      if (i == `LA_EXC_ID_SLOT) cause_exp = r.cause;
      check_field($sformatf("exc_cause[%0d]", i), 32'(dispatch.exc_cause[i]),
                  32'(cause_exp));
    end
    if (row_errs == 0) begin
      rows_ok++;
      $display("PASS %s %s", tag, r.name);
    end else begin
      rows_bad++;
      $display("FAIL %s %s with %0d wrong fields", tag, r.name, row_errs);
    end
  endtask

  initial begin
    int waited;
    void'($urandom(27010));
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    fetch_pkt   = '0;
    plv         = '0;
    csr_fwd     = '0;
    rows_ok     = 0;
    rows_bad    = 0;
    timing_errs = 0;
    build_table();
    repeat (10) @(posedge clk);
    #1;
    assert (out_valid === 1'b0) else begin
      $display("out_valid was high while reset was held.");
      timing_errs++;
    end
    rst_n = 1'b1;

    // One strobe per row with an idle cycle after each packet.
    foreach (rows[i]) begin
      drive_row(rows[i]);
      in_valid = 1'b1;
      @(posedge clk);
      #1;
      in_valid = 1'b0;
      waited   = 0;
      while (out_valid !== 1'b1 && waited < 5) begin
        @(posedge clk);
        #1;
        waited++;
      end
      if (out_valid !== 1'b1) begin
        rows_bad++;
        $display("Row %s timed out waiting for out_valid.", rows[i].name);
      end else begin
        check_row(rows[i], "single");
      end
      @(posedge clk);
      #1;
    end

    // Back to back, each packet is checked one cycle after its strobe.
    drive_row(rows[0]);
    in_valid = 1'b1;
    for (int i = 1; i <= rows.size(); i++) begin
      @(posedge clk);
      #1;
      check_row(rows[i-1], "stream");
      if (i < rows.size()) begin
        drive_row(rows[i]);
      end else begin
        in_valid = 1'b0;
      end
    end
    repeat (2) @(posedge clk);
    #1;

    $display("Rows passed %0d, rows failed %0d, timing errors %0d", rows_ok, rows_bad,
             timing_errs);
    if (rows_bad == 0 && timing_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
id_pkg.sv
dec_alu.sv
dec_mem.sv
dec_branch.sv
dec_priv.sv
id_dispatch.sv
id_stage.sv
tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f all.f --top-module tb_id_stage -o sim_id_stage &&
  ./obj_dir/sim_id_stage | tee /dev/stderr | grep "Test completed successfully" > /dev/null ||
  { echo "Simulation did not report a pass."; exit 1; }
